//--- xc_corr.f
logic/xc_cfg_pkg.sv
logic/xc_cmd_pkg.sv
logic/xc_sample_if.sv
logic/xc_delay_line.sv
logic/xc_corr_array.sv
logic/xc_cmd_parser.sv
logic/xc_packet_tx.sv
logic/xc_corr_top.sv
verif/xc_corr_tb.sv

//--- verif/xc_corr_stim.txt
# record: T name | S line_in ch3..ch0 | R count | C op chan arg | D | E word hexvalue | X
# op: 1 set_delay, 2 set_invert, 3 start, 4 stop, 5 clear
T reset_empty
D
E 0 0
E 18 0
T explicit_samples
S 0000
S 0000
C 3 0 0
S 1011
S 0011
S 1110
D
E 0 3
E 2 3
E 5 1
E 8 1
E 12 2
E 15 1
E 17 2
E 18 2
T random_zero_delay
R 60
D
T delay_taps
C 5 0 0
C 1 1 1
C 1 2 3
C 1 3 9
R 60
D
T inverted_channel
C 5 0 0
C 2 2 1
C 2 0 1
R 60
D
T stop_and_clear
C 4 0 0
R 30
D
C 5 0 0
D
E 0 0
E 18 0
X

//--- verif/xc_corr_tb.sv
`timescale 1ns/100ps

module xc_corr_tb import xc_cfg_pkg::*, xc_cmd_pkg::*; ();

	localparam int N = NUM_INPUTS;
	localparam int L = LAG_AUTO;
	localparam int R = RESOLUTION;
	localparam int HD = DELAY_SIZE + LAG_AUTO;
	localparam int NW = 1 + N + N * L + N * (N - 1) / 2;
	localparam int CMAX = (1 << R) - 1;
	localparam int TIMEOUT = 50;

	logic intclk;
	logic arst_n;
	logic smp_stb;
	logic [N-1:0] line_in;
	logic cmd_stb;
	xc_op_e cmd_op;
	logic [1:0] cmd_chan;
	logic [7:0] cmd_arg;
	logic pkt_valid;
	logic [R-1:0] pkt_data;
	logic pkt_last;
	logic pkt_busy;

	logic hist_m [N][HD]; // hist_m[c][k] holds the bit from k strobes ago.
	int delay_m [N];
	logic inv_m [N];
	logic en_m;
	int samp_m;
	int ones_m [N];
	int auto_m [N][L];
	int cross_m [N][N];
	int exp_pkt [NW];
	logic [R-1:0] rx_pkt [NW];
	logic [31:0] rng;
	string test_name;
	int errors;
	int test_errs;
	int tests_run;
	int tests_failed;

	xc_corr_top #(.NUM_INPUTS(N), .LAG_AUTO(L), .DELAY_SIZE(DELAY_SIZE), .RESOLUTION(R)) dut0 (
		.intclk, .arst_n, .smp_stb, .line_in, .cmd_stb, .cmd_op, .cmd_chan, .cmd_arg,
		.pkt_valid, .pkt_data, .pkt_last, .pkt_busy
	);

	always #4 intclk = ~intclk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] v;
		v = x ^ (x << 13);
		v = v ^ (v >> 17);
		return v ^ (v << 5);
	endfunction

	function automatic int sat_inc(input int v);
		return (v < CMAX) ? v + 1 : v;
	endfunction

	task automatic put(input logic s, input logic [N-1:0] bits, input logic c, input xc_op_e op,
		input int chan, input int arg);
		smp_stb = s;
		line_in = bits;
		cmd_stb = c;
		cmd_op = op;
		cmd_chan = 2'(chan);
		cmd_arg = 8'(arg);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAILED %s %s: expected %0h actual %0h", test_name, what, exp, act);
		errors++;
		test_errs++;
	endtask

	task automatic report_problem(input string msg);
		$display("%s: %s", test_name, msg);
		errors++;
		test_errs++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	task automatic clear_counts();
		samp_m = 0;
		for (int c = 0; c < N; c++) begin
			ones_m[c] = 0;
			for (int y = 0; y < L; y++)
				auto_m[c][y] = 0;
			for (int b = 0; b < N; b++)
				cross_m[c][b] = 0;
		end
	endtask

	task automatic model_sample(input logic [N-1:0] bits);
		logic taps [N][HD];
		logic rb [N];
		for (int c = 0; c < N; c++) begin
			taps[c][0] = bits[c] ^ inv_m[c]; // tap 0 is the live conditioned bit.
			for (int k = 1; k < HD; k++)
				taps[c][k] = hist_m[c][k];
			rb[c] = taps[c][delay_m[c]];
		end
		if (en_m) begin
			samp_m = sat_inc(samp_m);
			for (int c = 0; c < N; c++) begin
				if (rb[c])
					ones_m[c] = sat_inc(ones_m[c]);
				for (int y = 0; y < L; y++) begin
					if (rb[c] == taps[c][delay_m[c] + 1 + y])
						auto_m[c][y] = sat_inc(auto_m[c][y]);
				end
				for (int b = c + 1; b < N; b++) begin
					if (rb[c] == rb[b])
						cross_m[c][b] = sat_inc(cross_m[c][b]);
				end
			end
		end
		for (int c = 0; c < N; c++) begin
			for (int k = 1; k < HD; k++)
				hist_m[c][k] = taps[c][k - 1];
		end
	endtask

	task automatic model_cmd(input int op, input int chan, input int arg);
		case (xc_op_e'(op))
			OP_SET_DELAY: delay_m[chan] = (arg > DELAY_SIZE - 1) ? DELAY_SIZE - 1 : arg;
			OP_SET_INVERT: inv_m[chan] = arg[0];
			OP_START: en_m = 1'b1;
			OP_STOP: en_m = 1'b0;
			OP_CLEAR: clear_counts(); // history is left alone.
			default: begin
			end
		endcase
	endtask

	task automatic build_packet();
		int i;
		exp_pkt[0] = samp_m;
		i = 1;
		for (int c = 0; c < N; c++) begin
			exp_pkt[i] = ones_m[c];
			i++;
		end
		for (int c = 0; c < N; c++) begin
			for (int y = 0; y < L; y++) begin
				exp_pkt[i] = auto_m[c][y];
				i++;
			end
		end
		for (int a = 0; a < N; a++) begin
			for (int b = a + 1; b < N; b++) begin
				exp_pkt[i] = cross_m[a][b];
				i++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// dump and packet check
	//////////////////////////////////////////////////////////////////////

	task automatic run_dump();
		int wait_cnt;
		logic [N-1:0] bits;
		build_packet();
		@(negedge intclk);
		put(1'b0, '0, 1'b1, OP_DUMP, 0, 0);
		@(negedge intclk);
		put(1'b0, '0, 1'b0, OP_NOP, 0, 0);
		wait_cnt = 0;
		while (pkt_valid !== 1'b1 && wait_cnt < TIMEOUT) begin
			@(negedge intclk);
			wait_cnt++;
		end
		if (pkt_valid !== 1'b1) begin
			report_problem("the packet did not arrive");
			return;
		end
		if (wait_cnt != 0)
			report_mismatch("first word latency", 1, wait_cnt + 1);
		for (int w = 0; w < NW; w++) begin
			if (w > 0)
				@(negedge intclk);
			if (pkt_valid !== 1'b1) begin
				report_problem($sformatf("the packet stopped after %0d words", w));
				return;
			end
			rx_pkt[w] = pkt_data;
			if (pkt_data !== R'(exp_pkt[w]))
				report_mismatch($sformatf("word %0d", w), exp_pkt[w], pkt_data);
			if (pkt_last !== (w == NW - 1))
				report_mismatch($sformatf("pkt_last at word %0d", w), w == NW - 1, pkt_last);
			if (pkt_busy !== 1'b1)
				report_mismatch($sformatf("pkt_busy at word %0d", w), 1, pkt_busy);
			if (w == 2) begin
				put(1'b0, '0, 1'b1, OP_DUMP, 0, 0); // this one lands while busy.
			end else begin
				rng = xorshift(rng);
				bits = rng[N-1:0];
				put(1'b1, bits, 1'b0, OP_NOP, 0, 0); // sampling goes on under the packet.
				model_sample(bits);
			end
		end
		@(negedge intclk);
		put(1'b0, '0, 1'b0, OP_NOP, 0, 0);
		if (pkt_busy !== 1'b0)
			report_mismatch("pkt_busy after the last word", 0, pkt_busy);
		for (int k = 0; k < NW + 4; k++) begin
			if (pkt_valid !== 1'b0) begin
				report_problem("a second packet came from a dump sent while busy");
				return;
			end
			@(negedge intclk);
		end
	endtask

	task automatic finish_test();
		if (test_name != "") begin
			tests_run++;
			if (test_errs == 0) begin
				$display("test %s passed", test_name);
			end else begin
				tests_failed++;
				$display("test %s failed with %0d errors", test_name, test_errs);
			end
		end
		test_errs = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus file
	//////////////////////////////////////////////////////////////////////

	initial begin
		int fd;
		int code;
		int ch;
		int n;
		int op;
		int chan;
		int arg;
		int idx;
		logic [31:0] val;
		logic [N-1:0] bits;
		logic done;
		string tag;
		intclk = 1'b0;
		arst_n = 1'b0;
		put(1'b0, '0, 1'b0, OP_NOP, 0, 0);
		rng = 32'd46;
		errors = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		en_m = 1'b0;
		for (int c = 0; c < N; c++) begin
			delay_m[c] = 0;
			inv_m[c] = 1'b0;
			for (int k = 0; k < HD; k++)
				hist_m[c][k] = 1'b0;
		end
		clear_counts();
		repeat (4) @(posedge intclk);
		@(negedge intclk);
		arst_n = 1'b1;
		fd = $fopen("verif/xc_corr_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			errors++;
		end else begin
			done = 1'b0;
			while (!done) begin
				code = $fscanf(fd, " %s", tag);
				if (code != 1) begin
					report_problem("stimulus file ended without an X record");
					done = 1'b1;
				end else if (tag == "#") begin
					ch = 0;
					while (ch != 10 && ch != -1)
						ch = $fgetc(fd);
				end else if (tag == "T") begin
					finish_test();
					code = $fscanf(fd, " %s", test_name);
				end else if (tag == "S") begin
					code = $fscanf(fd, " %b", bits);
					@(negedge intclk);
					put(1'b1, bits, 1'b0, OP_NOP, 0, 0);
					model_sample(bits);
				end else if (tag == "R") begin
					code = $fscanf(fd, " %d", n);
					repeat (n) begin
						rng = xorshift(rng);
						bits = rng[N-1:0];
						@(negedge intclk);
						put(1'b1, bits, 1'b0, OP_NOP, 0, 0);
						model_sample(bits);
					end
				end else if (tag == "C") begin
					code = $fscanf(fd, " %d %d %d", op, chan, arg);
					@(negedge intclk);
					put(1'b0, '0, 1'b1, xc_op_e'(op), chan, arg);
					model_cmd(op, chan, arg);
				end else if (tag == "D") begin
					run_dump();
				end else if (tag == "E") begin
					code = $fscanf(fd, " %d %h", idx, val);
					if (rx_pkt[idx] !== R'(val))
						report_mismatch($sformatf("word %0d", idx), val, rx_pkt[idx]);
				end else if (tag == "X") begin
					finish_test();
					done = 1'b1;
				end else begin
					report_problem({"unknown stimulus record ", tag});
					done = 1'b1;
				end
			end
			$fclose(fd);
		end
		@(negedge intclk);
		put(1'b0, '0, 1'b0, OP_NOP, 0, 0);
		repeat (2) @(negedge intclk);
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- logic/xc_corr_top.sv
`timescale 1ns/100ps

module xc_corr_top import xc_cfg_pkg::*, xc_cmd_pkg::*; #(
	parameter int NUM_INPUTS = xc_cfg_pkg::NUM_INPUTS,
	parameter int LAG_AUTO = xc_cfg_pkg::LAG_AUTO,
	parameter int DELAY_SIZE = xc_cfg_pkg::DELAY_SIZE,
	parameter int RESOLUTION = xc_cfg_pkg::RESOLUTION
) (
	input logic intclk,
	input logic arst_n,
	input logic smp_stb,
	input logic [NUM_INPUTS-1:0] line_in,
	input logic cmd_stb,
	input xc_op_e cmd_op,
	input logic [1:0] cmd_chan,
	input logic [7:0] cmd_arg,
	output logic pkt_valid,
	output logic [RESOLUTION-1:0] pkt_data,
	output logic pkt_last,
	output logic pkt_busy
);

	localparam int NB = xc_num_baselines(NUM_INPUTS);
	localparam int PKT_WORDS = xc_num_words(NUM_INPUTS, LAG_AUTO);

	logic [NUM_INPUTS-1:0][xc_tap_bits(DELAY_SIZE)-1:0] delay;
	logic [NUM_INPUTS-1:0] invert;
	logic dump_stb;
	logic [NUM_INPUTS-1:0] ref_bits;
	logic [NUM_INPUTS*LAG_AUTO-1:0] lag_bits;
	logic [RESOLUTION-1:0] sample_cnt;
	logic [NUM_INPUTS*RESOLUTION-1:0] ones_cnt;
	logic [NUM_INPUTS*LAG_AUTO*RESOLUTION-1:0] auto_cnt;
	logic [NB*RESOLUTION-1:0] cross_cnt;

	xc_sample_if #(.NUM_INPUTS(NUM_INPUTS), .LAG_AUTO(LAG_AUTO)) smp_bus ();

	assign smp_bus.smp_stb = smp_stb;
	assign smp_bus.ref_bits = ref_bits;
	assign smp_bus.lag_bits = lag_bits;

	xc_cmd_parser #(.NUM_INPUTS(NUM_INPUTS), .DELAY_SIZE(DELAY_SIZE)) u_parser (
		.intclk, .arst_n, .cmd_stb, .cmd_op, .cmd_chan, .cmd_arg,
		.delay, .invert, .dump_stb, .smp(smp_bus)
	);

	for (genvar c = 0; c < NUM_INPUTS; c++) begin : g_chan
		xc_delay_line #(.DELAY_SIZE(DELAY_SIZE), .LAG_AUTO(LAG_AUTO)) u_dline (
			.intclk, .arst_n, .smp_stb, .bit_in(line_in[c]), .invert(invert[c]),
			.delay(delay[c]), .ref_bit(ref_bits[c]),
			.lag_bits(lag_bits[c*LAG_AUTO +: LAG_AUTO])
		);
	end

	xc_corr_array #(.NUM_INPUTS(NUM_INPUTS), .LAG_AUTO(LAG_AUTO), .RESOLUTION(RESOLUTION)) u_array (
		.intclk, .arst_n, .smp(smp_bus), .sample_cnt, .ones_cnt, .auto_cnt, .cross_cnt
	);

	xc_packet_tx #(.NUM_WORDS(PKT_WORDS), .RESOLUTION(RESOLUTION), .NUM_INPUTS(NUM_INPUTS),
		.LAG_AUTO(LAG_AUTO)) u_tx (
		.intclk, .arst_n, .dump_stb, .sample_cnt, .ones_cnt, .auto_cnt, .cross_cnt,
		.pkt_valid, .pkt_data, .pkt_last, .pkt_busy
	);

endmodule

//--- logic/xc_packet_tx.sv
`timescale 1ns/100ps

module xc_packet_tx import xc_cfg_pkg::*, xc_cmd_pkg::*; #(
	parameter int NUM_WORDS = xc_cfg_pkg::NUM_WORDS,
	parameter int RESOLUTION = xc_cfg_pkg::RESOLUTION,
	parameter int NUM_INPUTS = xc_cfg_pkg::NUM_INPUTS,
	parameter int LAG_AUTO = xc_cfg_pkg::LAG_AUTO
) (
	input logic intclk,
	input logic arst_n,
	input logic dump_stb,
	input logic [RESOLUTION-1:0] sample_cnt,
	input logic [NUM_INPUTS*RESOLUTION-1:0] ones_cnt,
	input logic [NUM_INPUTS*LAG_AUTO*RESOLUTION-1:0] auto_cnt,
	input logic [xc_num_baselines(NUM_INPUTS)*RESOLUTION-1:0] cross_cnt,
	output logic pkt_valid,
	output logic [RESOLUTION-1:0] pkt_data,
	output logic pkt_last,
	output logic pkt_busy
);

	localparam int IW = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

	xc_tx_state_e state;
	logic [IW-1:0] idx;
	logic [NUM_WORDS-1:0][RESOLUTION-1:0] snap;
	logic take;
	logic last_word;

	assign take = (state == TX_IDLE) && dump_stb; // a dump while sending is dropped.
	assign last_word = (idx == IW'(NUM_WORDS - 1));

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= TX_IDLE;
			idx <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (dump_stb) begin
						state <= TX_SEND;
						idx <= '0;
					end
				end
				TX_SEND: begin
					if (last_word) begin
						state <= TX_IDLE;
					end else begin
						idx <= idx + 1'b1;
					end
				end
			endcase
		end
	end

	// word 0 sits in the low bits, so the packet order follows the concatenation.
	always_ff @(posedge intclk) begin
		if (take) begin
			snap <= {cross_cnt, auto_cnt, ones_cnt, sample_cnt};
		end
	end

	assign pkt_valid = (state == TX_SEND);
	assign pkt_busy = (state == TX_SEND); // drops together with the last word.
	assign pkt_last = (state == TX_SEND) && last_word;
	assign pkt_data = snap[idx];

endmodule

//--- logic/xc_cmd_parser.sv
`timescale 1ns/100ps

module xc_cmd_parser import xc_cfg_pkg::*, xc_cmd_pkg::*; #(
	parameter int NUM_INPUTS = xc_cfg_pkg::NUM_INPUTS,
	parameter int DELAY_SIZE = xc_cfg_pkg::DELAY_SIZE
) (
	input logic intclk,
	input logic arst_n,
	input logic cmd_stb,
	input xc_op_e cmd_op,
	input logic [1:0] cmd_chan,
	input logic [7:0] cmd_arg,
	output logic [NUM_INPUTS-1:0][xc_tap_bits(DELAY_SIZE)-1:0] delay,
	output logic [NUM_INPUTS-1:0] invert,
	output logic dump_stb,
	xc_sample_if.fe smp
);

	localparam int TB = xc_tap_bits(DELAY_SIZE);
	localparam logic [7:0] ARG_MAX = 8'(DELAY_SIZE - 1);

	logic [TB-1:0] delay_arg;

	assign delay_arg = (cmd_arg > ARG_MAX) ? ARG_MAX[TB-1:0] : cmd_arg[TB-1:0];

	// both strobes act at the edge of the command itself.
	assign smp.clear = cmd_stb && (cmd_op == OP_CLEAR);
	assign dump_stb = cmd_stb && (cmd_op == OP_DUMP); // busy is checked in the serializer.

	//////////////////////////////////////////////////////////////////////
	// per-channel settings and the integrate flag
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			delay <= '0;
			invert <= '0;
			smp.count_en <= 1'b0;
		end else if (cmd_stb) begin
			case (cmd_op)
				OP_SET_DELAY: begin
					delay[cmd_chan] <= delay_arg;
				end
				OP_SET_INVERT: begin
					invert[cmd_chan] <= cmd_arg[0];
				end
				OP_START: begin
					smp.count_en <= 1'b1;
				end
				OP_STOP: begin
					smp.count_en <= 1'b0;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

//--- logic/xc_corr_array.sv
`timescale 1ns/100ps

module xc_corr_array import xc_cfg_pkg::*; #(
	parameter int NUM_INPUTS = xc_cfg_pkg::NUM_INPUTS,
	parameter int LAG_AUTO = xc_cfg_pkg::LAG_AUTO,
	parameter int RESOLUTION = xc_cfg_pkg::RESOLUTION
) (
	input logic intclk,
	input logic arst_n,
	xc_sample_if.ctr smp,
	output logic [RESOLUTION-1:0] sample_cnt,
	output logic [NUM_INPUTS*RESOLUTION-1:0] ones_cnt,
	output logic [NUM_INPUTS*LAG_AUTO*RESOLUTION-1:0] auto_cnt,
	output logic [xc_num_baselines(NUM_INPUTS)*RESOLUTION-1:0] cross_cnt
);

	localparam int R = RESOLUTION;

	logic tick;

	assign tick = smp.smp_stb & smp.count_en;

	// counts up on a hit and holds at all ones.
	function automatic logic [R-1:0] bump(input logic [R-1:0] cnt, input logic hit);
		if (hit && (cnt != '1)) begin
			return cnt + 1'b1;
		end
		return cnt;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// coincidence counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			sample_cnt <= '0;
			ones_cnt <= '0;
			auto_cnt <= '0;
			cross_cnt <= '0;
		end else if (smp.clear) begin
			sample_cnt <= '0; // the history in the delay lines is kept.
			ones_cnt <= '0;
			auto_cnt <= '0;
			cross_cnt <= '0;
		end else if (tick) begin
			sample_cnt <= bump(sample_cnt, 1'b1);
			for (int c = 0; c < NUM_INPUTS; c++) begin
				ones_cnt[c*R +: R] <= bump(ones_cnt[c*R +: R], smp.ref_bits[c]);
				for (int y = 0; y < LAG_AUTO; y++) begin
					auto_cnt[(c*LAG_AUTO+y)*R +: R] <= bump(auto_cnt[(c*LAG_AUTO+y)*R +: R],
						smp.ref_bits[c] ~^ smp.lag_bits[c*LAG_AUTO+y]);
				end
				for (int b = c + 1; b < NUM_INPUTS; b++) begin
					cross_cnt[xc_pair_idx(c, b, NUM_INPUTS)*R +: R] <=
						bump(cross_cnt[xc_pair_idx(c, b, NUM_INPUTS)*R +: R],
						smp.ref_bits[c] ~^ smp.ref_bits[b]);
				end
			end
		end
	end

endmodule

//--- logic/xc_delay_line.sv
`timescale 1ns/100ps

module xc_delay_line import xc_cfg_pkg::*; #(
	parameter int DELAY_SIZE = xc_cfg_pkg::DELAY_SIZE,
	parameter int LAG_AUTO = xc_cfg_pkg::LAG_AUTO
) (
	input logic intclk,
	input logic arst_n,
	input logic smp_stb,
	input logic bit_in,
	input logic invert,
	input logic [xc_tap_bits(DELAY_SIZE)-1:0] delay,
	output logic ref_bit,
	output logic [LAG_AUTO-1:0] lag_bits
);

	localparam int HIST = xc_hist_depth(DELAY_SIZE, LAG_AUTO);

	logic cond_bit;
	logic [HIST-1:1] hist; // hist[k] is the bit from k strobes ago.
	logic [HIST-1:0] taps;

	assign cond_bit = bit_in ^ invert;
	assign taps = {hist, cond_bit}; // tap 0 comes straight from the input.

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			hist <= '0;
		end else if (smp_stb) begin
			hist <= taps[HIST-2:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// tap selection
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ref_bit = taps[delay];
		for (int y = 0; y < LAG_AUTO; y++) begin
			lag_bits[y] = taps[int'(delay) + 1 + y]; // the parser keeps delay in range.
		end
	end

endmodule

//--- logic/xc_sample_if.sv
`timescale 1ns/100ps

interface xc_sample_if #(
	parameter int NUM_INPUTS = xc_cfg_pkg::NUM_INPUTS,
	parameter int LAG_AUTO = xc_cfg_pkg::LAG_AUTO
) ();

	logic smp_stb;
	logic [NUM_INPUTS-1:0] ref_bits; // one reference bit per channel.
	logic [NUM_INPUTS*LAG_AUTO-1:0] lag_bits; // channel c owns bits c*LAG_AUTO and up.
	logic count_en;
	logic clear;

	// front end drives the bits and the control.
	modport fe (
		output smp_stb, ref_bits, lag_bits, count_en, clear
	);

	modport ctr (
		input smp_stb, ref_bits, lag_bits, count_en, clear
	);

endinterface

//--- logic/xc_cmd_pkg.sv
package xc_cmd_pkg;

	//////////////////////////////////////////////////////////////////////
	// command port opcodes
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		OP_NOP        = 3'd0,
		OP_SET_DELAY  = 3'd1, // arg is the tap index, clamped.
		OP_SET_INVERT = 3'd2, // arg bit 0 is the invert flag.
		OP_START      = 3'd3,
		OP_STOP       = 3'd4,
		OP_CLEAR      = 3'd5,
		OP_DUMP       = 3'd6
	} xc_op_e;

	// packet serializer states.
	typedef enum logic {
		TX_IDLE = 1'b0,
		TX_SEND = 1'b1
	} xc_tx_state_e;

endpackage

//--- logic/xc_cfg_pkg.sv
package xc_cfg_pkg;

	//////////////////////////////////////////////////////////////////////
	// default geometry of the correlator
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_INPUTS = 4;
	localparam int LAG_AUTO = 2; // auto lags counted after the reference tap.
	localparam int DELAY_SIZE = 4; // tap 0 is the undelayed bit.
	localparam int RESOLUTION = 16;

	function automatic int xc_num_baselines(input int n);
		return n * (n - 1) / 2;
	endfunction

	function automatic int xc_hist_depth(input int delay_size, input int lags);
		return delay_size + lags;
	endfunction

	function automatic int xc_tap_bits(input int delay_size);
		return (delay_size > 1) ? $clog2(delay_size) : 1;
	endfunction

	// packet is sample count, then ones, then auto by channel and lag, then cross.
	function automatic int xc_num_words(input int n, input int lags);
		return 1 + n + n * lags + xc_num_baselines(n);
	endfunction

	// word offset of baseline (a,b) with a below b, in (0,1), (0,2) order.
	function automatic int xc_pair_idx(input int a, input int b, input int n);
		return a * (2 * n - a - 1) / 2 + (b - a - 1);
	endfunction

	localparam int HIST_DEPTH = xc_hist_depth(DELAY_SIZE, LAG_AUTO);
	localparam int NUM_BASELINES = xc_num_baselines(NUM_INPUTS);
	localparam int NUM_WORDS = xc_num_words(NUM_INPUTS, LAG_AUTO);

endpackage
